/* decodeStage.sv */
module decodeStage (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [pipePkg::dataWidth-1:0]     instr,
  input  logic                              instrValid,
  input  logic                              stall,     // Load-use hold
  output logic [pipePkg::regAddrWidth-1:0]  rnD,
  output logic [pipePkg::regAddrWidth-1:0]  rmD,
  output logic                              validD,
  output logic [pipePkg::opWidth-1:0]       opD,
  output logic [pipePkg::regAddrWidth-1:0]  rdD,
  output logic [pipePkg::dataWidth-1:0]     immD,
  output logic                              immSelD,
  output logic [pipePkg::dataWidth-1:0]     rd1D,
  output logic [pipePkg::dataWidth-1:0]     rd2D,
  output logic [pipePkg::regAddrWidth-1:0]  ra1,       // To register file
  output logic [pipePkg::regAddrWidth-1:0]  ra2,
  input  logic [pipePkg::dataWidth-1:0]     rd1,       // From register file
  input  logic [pipePkg::dataWidth-1:0]     rd2
);

  logic [pipePkg::dataWidth-1:0] instrReg;   // Instruction held in decode
  logic                          validReg;
  logic [pipePkg::opWidth-1:0]   opField;
  logic                          realOp;     // Opcode does actual work

  // Instruction register
  // Keeps its contents while stalled so the source and decode stay in step
  always_ff @(posedge clk) begin
    if (reset) begin
      instrReg <= '0;   // Decodes as a nop
      validReg <= 1'b0;
    end else if (!stall) begin
      instrReg <= instr;
      validReg <= instrValid;
    end
  end

  // Field split
  assign opField = instrReg[pipePkg::opMsb:pipePkg::opLsb];
  assign rdD     = instrReg[pipePkg::rdMsb:pipePkg::rdLsb];
  assign rnD     = instrReg[pipePkg::rnMsb:pipePkg::rnLsb];
  assign rmD     = instrReg[pipePkg::rmMsb:pipePkg::rmLsb];
  assign immSelD = instrReg[pipePkg::immFlagBit];
  assign opD     = opField;

  // Zero-extended 12-bit immediate
  assign immD = {{(pipePkg::dataWidth - pipePkg::immMsb - 1){1'b0}},
                 instrReg[pipePkg::immMsb:0]};

  // Nops and undefined opcodes carry no work down the pipe
  assign realOp = (opField >= pipePkg::opAdd) && (opField <= pipePkg::opStr);
  assign validD = validReg && realOp;

  // Register read
  assign ra1  = rnD;
  assign ra2  = rmD;
  assign rd1D = rd1;   // Already write-first inside the file
  assign rd2D = rd2;

endmodule

/* executeStage.sv */
module executeStage (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              stall,     // Insert a bubble
  input  logic [pipePkg::regAddrWidth-1:0]  rnD,
  input  logic [pipePkg::regAddrWidth-1:0]  rmD,
  input  logic                              validD,
  input  logic [pipePkg::opWidth-1:0]       opD,
  input  logic [pipePkg::regAddrWidth-1:0]  rdD,
  input  logic [pipePkg::dataWidth-1:0]     immD,
  input  logic                              immSelD,
  input  logic [pipePkg::dataWidth-1:0]     rd1D,
  input  logic [pipePkg::dataWidth-1:0]     rd2D,
  input  logic [pipePkg::fwdWidth-1:0]      fwdA,
  input  logic [pipePkg::fwdWidth-1:0]      fwdB,
  input  logic [pipePkg::dataWidth-1:0]     aluM,      // Bypass from memory stage
  input  logic [pipePkg::dataWidth-1:0]     resultW,   // Bypass from write-back
  output logic [pipePkg::regAddrWidth-1:0]  rnE,
  output logic [pipePkg::regAddrWidth-1:0]  rmE,
  output logic [pipePkg::regAddrWidth-1:0]  rdE,
  output logic [pipePkg::opWidth-1:0]       opE,
  output logic                              validE,
  output logic [pipePkg::dataWidth-1:0]     aluE,
  output logic [pipePkg::dataWidth-1:0]     storeDataE
);

  logic [pipePkg::dataWidth-1:0] rd1E;
  logic [pipePkg::dataWidth-1:0] rd2E;
  logic [pipePkg::dataWidth-1:0] immE;
  logic                          immSelE;
  logic [pipePkg::dataWidth-1:0] srcA;
  logic [pipePkg::dataWidth-1:0] fwdRm;    // Forwarded second source
  logic [pipePkg::dataWidth-1:0] srcB;
  logic                          memOpE;   // Load or store
  logic                          useImm;

  // Three-way bypass select
  function automatic logic [pipePkg::dataWidth-1:0] bypass(
    input logic [pipePkg::fwdWidth-1:0]  sel,
    input logic [pipePkg::dataWidth-1:0] regVal,
    input logic [pipePkg::dataWidth-1:0] wbVal,
    input logic [pipePkg::dataWidth-1:0] memVal
  );
    case (sel)
      pipePkg::fwdWb:  bypass = wbVal;
      pipePkg::fwdMem: bypass = memVal;
      default:         bypass = regVal;   // fwdReg
    endcase
  endfunction

  // Control half of the pipeline register
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      validE <= 1'b0;   // Bubble on stall
      opE    <= pipePkg::opNop;
    end else begin
      validE <= validD;
      opE    <= opD;
    end
  end

  // Payload half holds during a bubble
  always_ff @(posedge clk) begin
    if (!stall) begin
      rnE     <= rnD;
      rmE     <= rmD;
      rdE     <= rdD;
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      immE    <= immD;
      immSelE <= immSelD;
    end
  end

  // Operand bypass
  assign srcA  = bypass(fwdA, rd1E, resultW, aluM);
  assign fwdRm = bypass(fwdB, rd2E, resultW, aluM);

  // Addresses are always rn plus immediate
  assign memOpE = (opE == pipePkg::opLdr) || (opE == pipePkg::opStr);
  assign useImm = immSelE || memOpE;
  assign srcB   = useImm ? immE : fwdRm;

  assign storeDataE = fwdRm;   // Store writes rm

  // ALU
  always_comb begin
    case (opE)
      pipePkg::opAdd,
      pipePkg::opLdr,
      pipePkg::opStr: aluE = srcA + srcB;
      pipePkg::opSub: aluE = srcA - srcB;
      pipePkg::opAnd: aluE = srcA & srcB;
      pipePkg::opOrr: aluE = srcA | srcB;
      pipePkg::opEor: aluE = srcA ^ srcB;
      pipePkg::opMov: aluE = srcB;
      default:        aluE = '0;   // Nop or undefined
    endcase
  end

endmodule

/* hazardUnit.sv */
module hazardUnit (
  input  logic [pipePkg::regAddrWidth-1:0]  rnD,
  input  logic [pipePkg::regAddrWidth-1:0]  rmD,
  input  logic                              validD,
  input  logic [pipePkg::regAddrWidth-1:0]  rnE,
  input  logic [pipePkg::regAddrWidth-1:0]  rmE,
  input  logic [pipePkg::regAddrWidth-1:0]  rdE,
  input  logic [pipePkg::opWidth-1:0]       opE,
  input  logic                              validE,
  input  logic [pipePkg::regAddrWidth-1:0]  rdM,
  input  logic                              writeM,
  input  logic [pipePkg::regAddrWidth-1:0]  rdW,
  input  logic                              writeW,
  output logic [pipePkg::fwdWidth-1:0]      fwdA,
  output logic [pipePkg::fwdWidth-1:0]      fwdB,
  output logic                              stall
);

  logic loadE;     // Execute holds a valid load
  logic matchD;    // A decode source needs the load result

  // Bypass choice for one execute source
  // Memory stage wins since it holds the younger write
  function automatic logic [pipePkg::fwdWidth-1:0] pickFwd(
    input logic [pipePkg::regAddrWidth-1:0] src
  );
    if (writeM && (rdM == src)) begin
      pickFwd = pipePkg::fwdMem;
    end else if (writeW && (rdW == src)) begin
      pickFwd = pipePkg::fwdWb;
    end else begin
      pickFwd = pipePkg::fwdReg;
    end
  endfunction

  assign fwdA = pickFwd(rnE);
  assign fwdB = pickFwd(rmE);   // Also feeds store data

  // Load-use check between execute and decode
  // A load never forwards from memory because of this one-cycle hold
  assign loadE  = validE && (opE == pipePkg::opLdr);
  assign matchD = (rdE == rnD) || (rdE == rmD);
  assign stall  = loadE && validD && matchD;

endmodule

/* list.f */
pipePkg.sv
regFile.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
pipeCore.sv
pipeCoreTb.sv

/* memoryStage.sv */
module memoryStage (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [pipePkg::dataWidth-1:0]     aluE,
  input  logic [pipePkg::dataWidth-1:0]     storeDataE,
  input  logic [pipePkg::regAddrWidth-1:0]  rdE,
  input  logic [pipePkg::opWidth-1:0]       opE,
  input  logic                              validE,
  output logic [pipePkg::regAddrWidth-1:0]  rdM,
  output logic                              writeM,
  output logic [pipePkg::dataWidth-1:0]     aluM,
  output logic [pipePkg::regAddrWidth-1:0]  rdW,
  output logic                              writeW,
  output logic [pipePkg::dataWidth-1:0]     resultW,
  output logic                              wbValid,
  output logic [pipePkg::regAddrWidth-1:0]  wbReg,
  output logic [pipePkg::dataWidth-1:0]     wbData
);

  logic                              validM;
  logic [pipePkg::opWidth-1:0]       opM;
  logic [pipePkg::dataWidth-1:0]     storeDataM;
  logic [pipePkg::memAddrWidth-1:0]  memIdx;     // Word index, address mod 16
  logic [pipePkg::dataWidth-1:0]     loadDataM;
  logic [pipePkg::dataWidth-1:0]     loadDataW;
  logic [pipePkg::dataWidth-1:0]     aluW;
  logic                              loadW;      // Write-back takes memory data
  logic [pipePkg::dataWidth-1:0]     dataMem [pipePkg::memWords];

  // Stage control
  always_ff @(posedge clk) begin
    if (reset) begin
      validM <= 1'b0;
      opM    <= pipePkg::opNop;
      writeW <= 1'b0;
      loadW  <= 1'b0;
    end else begin
      validM <= validE;
      opM    <= opE;
      writeW <= writeM;
      loadW  <= validM && (opM == pipePkg::opLdr);
    end
  end

  // Stage payload
  always_ff @(posedge clk) begin
    aluM       <= aluE;
    storeDataM <= storeDataE;
    rdM        <= rdE;
    rdW        <= rdM;
    aluW       <= aluM;
    loadDataW  <= loadDataM;   // Registered load result
  end

  assign memIdx = aluM[pipePkg::memAddrWidth-1:0];

  // Data memory
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < pipePkg::memWords; i++) begin
        dataMem[i] <= '0;
      end
    end else if (validM && (opM == pipePkg::opStr)) begin
      dataMem[memIdx] <= storeDataM;
    end
  end

  assign loadDataM = dataMem[memIdx];   // Async read

  // Stores and bubbles leave the register file alone
  assign writeM = validM && (opM != pipePkg::opStr);

  assign resultW = loadW ? loadDataW : aluW;

  // Retire port
  assign wbValid = writeW;
  assign wbReg   = rdW;
  assign wbData  = resultW;

endmodule

/* pipeCore.sv */
module pipeCore (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [pipePkg::dataWidth-1:0]     instr,
  input  logic                              instrValid,
  output logic                              stall,     // Source must hold instr
  output logic                              wbValid,
  output logic [pipePkg::regAddrWidth-1:0]  wbReg,
  output logic [pipePkg::dataWidth-1:0]     wbData
);

  // Decode outputs
  logic [pipePkg::regAddrWidth-1:0] rnD;
  logic [pipePkg::regAddrWidth-1:0] rmD;
  logic [pipePkg::regAddrWidth-1:0] rdD;
  logic                             validD;
  logic [pipePkg::opWidth-1:0]      opD;
  logic [pipePkg::dataWidth-1:0]    immD;
  logic                             immSelD;
  logic [pipePkg::dataWidth-1:0]    rd1D;
  logic [pipePkg::dataWidth-1:0]    rd2D;
  // Register file port
  logic [pipePkg::regAddrWidth-1:0] ra1;
  logic [pipePkg::regAddrWidth-1:0] ra2;
  logic [pipePkg::dataWidth-1:0]    rd1;
  logic [pipePkg::dataWidth-1:0]    rd2;
  // Execute outputs
  logic [pipePkg::regAddrWidth-1:0] rnE;
  logic [pipePkg::regAddrWidth-1:0] rmE;
  logic [pipePkg::regAddrWidth-1:0] rdE;
  logic [pipePkg::opWidth-1:0]      opE;
  logic                             validE;
  logic [pipePkg::dataWidth-1:0]    aluE;
  logic [pipePkg::dataWidth-1:0]    storeDataE;
  // Memory and write-back
  logic [pipePkg::regAddrWidth-1:0] rdM;
  logic                             writeM;
  logic [pipePkg::dataWidth-1:0]    aluM;
  logic [pipePkg::regAddrWidth-1:0] rdW;
  logic                             writeW;
  logic [pipePkg::dataWidth-1:0]    resultW;
  logic [pipePkg::fwdWidth-1:0]     fwdA;   // Bypass selects
  logic [pipePkg::fwdWidth-1:0]     fwdB;

  decodeStage decodeStage_inst (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid), .stall(stall),
    .rnD(rnD), .rmD(rmD), .validD(validD), .opD(opD), .rdD(rdD),
    .immD(immD), .immSelD(immSelD), .rd1D(rd1D), .rd2D(rd2D),
    .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2)
  );

  regFile regFile_inst (
    .clk(clk), .reset(reset), .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
    .we(writeW), .wa(rdW), .wd(resultW)   // Written from write-back
  );

  hazardUnit hazardUnit_inst (
    .rnD(rnD), .rmD(rmD), .validD(validD),
    .rnE(rnE), .rmE(rmE), .rdE(rdE), .opE(opE), .validE(validE),
    .rdM(rdM), .writeM(writeM), .rdW(rdW), .writeW(writeW),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
  );

  executeStage executeStage_inst (
    .clk(clk), .reset(reset), .stall(stall),
    .rnD(rnD), .rmD(rmD), .validD(validD), .opD(opD), .rdD(rdD),
    .immD(immD), .immSelD(immSelD), .rd1D(rd1D), .rd2D(rd2D),
    .fwdA(fwdA), .fwdB(fwdB), .aluM(aluM), .resultW(resultW),
    .rnE(rnE), .rmE(rmE), .rdE(rdE), .opE(opE), .validE(validE),
    .aluE(aluE), .storeDataE(storeDataE)
  );

  memoryStage memoryStage_inst (
    .clk(clk), .reset(reset), .aluE(aluE), .storeDataE(storeDataE),
    .rdE(rdE), .opE(opE), .validE(validE),
    .rdM(rdM), .writeM(writeM), .aluM(aluM),
    .rdW(rdW), .writeW(writeW), .resultW(resultW),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

/* pipeCoreTb.sv */
module pipeCoreTb;

  localparam int numRandom      = 400;
  localparam int numDirected    = 164;   // Reset reads and the directed sections
  localparam int instrTotal     = numDirected + numRandom;
  localparam int watchdogCycles = instrTotal * 3 + 50;

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic        instrValid;
  logic        stall;
  logic        wbValid;
  logic [3:0]  wbReg;
  logic [31:0] wbData;

  // Reference state
  logic [31:0] modelRegs [16];
  logic [31:0] modelMem  [16];
  logic [35:0] expQ [$];            // Expected writes as {register, value}
  logic        stallSeen;           // Stall in the cycle before the next edge
  integer      seed = 32'h3c7e3003;
  int          errorCount   = 0;    // Wrong or unexpected writes
  int          otherErrors  = 0;    // Control and sequencing problems
  int          checkedCount = 0;
  int          stallCount   = 0;

  pipeCore pipeCore_inst (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid), .stall(stall),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  always #2 clk = ~clk;   // Period 4

  // Instruction word from its fields
  function automatic logic [31:0] encode(input logic [3:0] op, input int rd, input int rn,
                                         input int rm, input int useImm, input int imm);
    encode = {op, rd[3:0], rn[3:0], rm[3:0], useImm[0], 3'b000, imm[11:0]};
  endfunction

  // Sequential execution of one instruction on the model state
  function automatic void refExecute(input logic [31:0] ins, output logic hasWrite,
                                     output logic [3:0] dst, output logic [31:0] val);
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    op       = ins[31:28];
    dst      = ins[27:24];
    imm      = {20'd0, ins[11:0]};   // Zero-extended
    a        = modelRegs[ins[23:20]];
    b        = ins[15] ? imm : modelRegs[ins[19:16]];
    addr     = a + imm;              // Loads and stores always add the immediate
    hasWrite = 1'b1;
    val      = '0;
    case (op)
      pipePkg::opAdd: val = a + b;
      pipePkg::opSub: val = a - b;
      pipePkg::opAnd: val = a & b;
      pipePkg::opOrr: val = a | b;
      pipePkg::opEor: val = a ^ b;
      pipePkg::opMov: val = b;
      pipePkg::opLdr: val = modelMem[addr[3:0]];   // Word index wraps at 16
      pipePkg::opStr: begin
        modelMem[addr[3:0]] = modelRegs[ins[19:16]];
        hasWrite = 1'b0;
      end
      default: hasWrite = 1'b0;   // Nop and undefined
    endcase
    if (hasWrite) begin
      modelRegs[dst] = val;
    end
  endfunction

  // Present one instruction and hold it until decode takes it
  task automatic sendInstr(input logic [31:0] ins);
    logic        hasWrite;
    logic [3:0]  dst;
    logic [31:0] val;
    instr      <= ins;
    instrValid <= 1'b1;
    @(posedge clk);
    while (stallSeen) begin
      @(posedge clk);   // Held while stalled
    end
    refExecute(ins, hasWrite, dst, val);
    if (hasWrite) begin
      expQ.push_back({dst, val});
    end
  endtask

  task automatic idleCycles(input int n);
    instrValid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // Write-back checker
  always @(negedge clk) begin
    logic [35:0] expEntry;
    stallSeen = stall;
    if (!reset) begin
      if (stall) begin
        stallCount++;
      end
      if (wbValid) begin
        assert (expQ.size() != 0) else begin
          $display("Register write to r%0d with no instruction left to retire", wbReg);
          errorCount++;
        end
        if (expQ.size() != 0) begin
          expEntry = expQ.pop_front();
          checkedCount++;
          assert (wbReg === expEntry[35:32]) else begin
            $display("FAIL wbReg got %h expected %h", wbReg, expEntry[35:32]);
            errorCount++;
          end
          assert (wbData === expEntry[31:0]) else begin
            $display("FAIL wbData got %h expected %h at r%0d",
                     wbData, expEntry[31:0], expEntry[35:32]);
            errorCount++;
          end
        end
      end
    end
  end

  // Stimulus
  initial begin
    logic [31:0] word;
    logic [3:0]  aluOp;
    int          stallMark;
    int          opPick;
    clk        = 1'b0;
    reset      = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    stallSeen  = 1'b0;
    for (int r = 0; r < 16; r++) begin
      modelRegs[r] = '0;
      modelMem[r]  = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (wbValid === 1'b0) else begin
      $display("FAIL wbValid got %h expected 0", wbValid);
      otherErrors++;
    end
    assert (stall === 1'b0) else begin
      $display("FAIL stall got %h expected 0", stall);
      otherErrors++;
    end
    @(posedge clk);

    // Freshly reset registers read as zero
    sendInstr(encode(pipePkg::opOrr, 1, 2, 3, 0, 0));
    sendInstr(encode(pipePkg::opAdd, 4, 5, 6, 0, 0));
    sendInstr(encode(pipePkg::opEor, 7, 8, 9, 0, 0));

    // Immediate moves into every register, then each ALU op on them
    for (int r = 0; r < 16; r++) begin
      sendInstr(encode(pipePkg::opMov, r, 0, 0, 1, r * 165 + 49));
    end
    for (aluOp = pipePkg::opAdd; aluOp <= pipePkg::opMov; aluOp++) begin
      for (int i = 0; i < 8; i++) begin
        sendInstr(encode(aluOp, (i * 3 + 1) % 16, i * 2, 15 - i, i % 2, i * 273));
      end
    end

    // Dependent chain at distances one, two and three
    stallMark = stallCount;
    for (int i = 0; i < 8; i++) begin
      sendInstr(encode(pipePkg::opAdd, 2, 5, 2, 0, 0));   // r5 from memory stage
      sendInstr(encode(pipePkg::opSub, 3, 2, 1, 0, 0));
      sendInstr(encode(pipePkg::opEor, 4, 3, 2, 0, 0));   // r2 from write-back
      sendInstr(encode(pipePkg::opOrr, 5, 4, 2, 0, 0));   // r2 through write-first read
    end
    assert (stallCount == stallMark) else begin
      $display("Forwarding chain without loads raised stall");
      otherErrors++;
    end

    // Stores, then loads from the same and the aliased word
    sendInstr(encode(pipePkg::opMov, 7, 0, 0, 1, 5));   // Base address
    for (int i = 0; i < 8; i++) begin
      sendInstr(encode(pipePkg::opMov, 6, 0, 0, 1, i * 291 + 7));
      sendInstr(encode(pipePkg::opStr, 0, 7, 6, 1, i));
      sendInstr(encode(pipePkg::opLdr, 8, 7, 0, 1, i + 16));   // Alias mod 16
      sendInstr(encode(pipePkg::opLdr, 9, 7, 0, 1, i));
    end

    // Load results used at once
    stallMark = stallCount;
    for (int i = 0; i < 8; i++) begin
      sendInstr(encode(pipePkg::opLdr, 10, 7, 0, 1, i));
      sendInstr(encode(pipePkg::opAdd, 11, 10, 10, 0, 0));
      sendInstr(encode(pipePkg::opLdr, 12, 7, 0, 1, i + 1));
      sendInstr(encode(pipePkg::opStr, 0, 7, 12, 1, i + 8));   // Store data from load
    end
    assert (stallCount > stallMark) else begin
      $display("Load-use sequence never raised stall");
      otherErrors++;
    end

    // Random mix with nops, undefined opcodes and idle gaps
    for (int n = 0; n < numRandom; n++) begin
      word         = $random(seed);
      opPick       = {$random(seed)} % 11;
      word[31:28]  = opPick[3:0];
      sendInstr(word);
      if ({$random(seed)} % 8 == 0) begin
        idleCycles(1 + {$random(seed)} % 3);
      end
    end

    // Drain, then watch the empty pipe for stray writes
    idleCycles(1);
    while (expQ.size() != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);

    $display("Checked %0d writes, %0d write errors, %0d other errors",
             checkedCount, errorCount, otherErrors);
    if (errorCount == 0 && otherErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout after %0d cycles with %0d expected writes not retired",
             watchdogCycles, expQ.size());
    $display("test failed");
    $finish;
  end

endmodule

/* pipePkg.sv */
package pipePkg;

  // Datapath sizes
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;
  localparam int numRegs      = 16;
  localparam int memAddrWidth = 4;
  localparam int memWords     = 16;
  localparam int opWidth      = 4;   // Opcode field width
  localparam int fwdWidth     = 2;   // Bypass select width

  // Opcodes in the top nibble of the instruction
  localparam logic [opWidth-1:0] opNop = 4'd0;
  localparam logic [opWidth-1:0] opAdd = 4'd1;
  localparam logic [opWidth-1:0] opSub = 4'd2;
  localparam logic [opWidth-1:0] opAnd = 4'd3;
  localparam logic [opWidth-1:0] opOrr = 4'd4;
  localparam logic [opWidth-1:0] opEor = 4'd5;
  localparam logic [opWidth-1:0] opMov = 4'd6;   // Result is operand B
  localparam logic [opWidth-1:0] opLdr = 4'd7;
  localparam logic [opWidth-1:0] opStr = 4'd8;   // Last real opcode

  // Instruction field positions
  localparam int opMsb = 31;
  localparam int opLsb = 28;
  localparam int rdMsb = 27;   // Destination
  localparam int rdLsb = 24;
  localparam int rnMsb = 23;   // First source
  localparam int rnLsb = 20;
  localparam int rmMsb = 19;   // Second source
  localparam int rmLsb = 16;
  localparam int immFlagBit = 15;   // Immediate as operand B
  localparam int immMsb     = 11;   // Immediate is bits 11..0

  // Bypass selects for the execute operands
  localparam logic [fwdWidth-1:0] fwdReg = 2'd0;   // Value read in decode
  localparam logic [fwdWidth-1:0] fwdWb  = 2'd1;   // Write-back result
  localparam logic [fwdWidth-1:0] fwdMem = 2'd2;   // Memory-stage ALU result

endpackage

/* regFile.sv */
module regFile (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [pipePkg::regAddrWidth-1:0]  ra1,   // Read port 1 index
  input  logic [pipePkg::regAddrWidth-1:0]  ra2,   // Read port 2 index
  output logic [pipePkg::dataWidth-1:0]     rd1,
  output logic [pipePkg::dataWidth-1:0]     rd2,
  input  logic                              we,    // Write enable from write-back
  input  logic [pipePkg::regAddrWidth-1:0]  wa,
  input  logic [pipePkg::dataWidth-1:0]     wd
);

  logic [pipePkg::dataWidth-1:0] regs [pipePkg::numRegs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < pipePkg::numRegs; i++) begin
        regs[i] <= '0;   // All registers start at zero
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-first read
  // A same-cycle write shows up at the read port so decode gets the new value
  assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
  assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
  --top-module pipeCoreTb \
  -f list.f \
  -o pipeCoreSim

./obj_dir/pipeCoreSim | tee "$LOG"

# Pass only when the testbench printed its pass line
grep -qx "test passed" "$LOG"
